// File: fpu_calc.f
+incdir+.
rtl/fpu_calc_pkg.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/fpu_core.sv
rtl/calc_ctrl.sv
rtl/fpu_calc_top.sv
test/fpu_calc_checker.sv
test/fpu_calc_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the calculator testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module fpu_calc_tb \
    -Mdir obj_dir -f fpu_calc.f
status=0
./obj_dir/Vfpu_calc_tb > sim.log 2>&1 || status=$?
cat sim.log
if [ "$status" -ne 0 ] || grep -q "=== FAIL ===" sim.log || ! grep -q "=== PASS ===" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"

// File: test/fpu_calc_tb.sv
/* Testbench for the serial floating-point calculator
   Drives random commands over rxd and checks txd replies against a model */
`timescale 1ns/1ps
`default_nettype none
`include "fpu_calc_defs.svh"

module fpu_calc_tb;

    localparam int TIMEOUT_CYCLES = 300 * 4 * 10 * `CLKS_PER_BIT * 2;

    logic        clk = 1'b0;
    logic        reset;
    logic        rxd;
    logic        txd;
    integer      seed = 32'hc954_9edf;
    int          checks = 0;
    int          errors = 0;
    int          cycle_cnt = 0;
    bit          finished = 1'b0;
    logic [22:0] m_r1 = '0;
    logic [22:0] m_r2 = '0;
    logic [22:0] m_res = '0;
    logic [2:0]  m_flags = '0; // Underflow, overflow, zero
    logic [22:0] a;
    logic [22:0] b;
    logic [31:0] r;

    // Overflow on add and multiply, underflow on multiply and subtract
    logic [22:0] dir_a [4] = '{{1'b0, 7'd127, 15'h4000}, {1'b1, 7'd120, 15'h1234},
                               {1'b0, 7'd10, 15'h2a5c}, {1'b0, 7'd1, 15'h0010}};
    logic [22:0] dir_b [4] = '{{1'b0, 7'd127, 15'h6000}, {1'b0, 7'd100, 15'h7000},
                               {1'b1, 7'd20, 15'h0f0f}, {1'b0, 7'd1, 15'h0000}};
    logic [7:0]  dir_op [4] = '{`CMD_ADD, `CMD_MUL, `CMD_MUL, `CMD_SUB};

    fpu_calc_top fpu_calc_top_inst (
        .clk   (clk),
        .reset (reset),
        .rxd   (rxd),
        .txd   (txd)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            finished = 1'b1;
            $display("Timeout: the test did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("=== FAIL ===");
            $finish;
        end
    end

    final begin
        if (!finished) begin
            $display("The run stopped before the test finished");
            $display("=== FAIL ===");
        end
    end

    function automatic logic [22:0] rand_value();
        logic [31:0] v;
        v = $random(seed);
        return {v[22], 7'(32 + v[21:16]), v[14:0]}; // Exponent 32 to 95
    endfunction

    function automatic logic [7:0] junk_byte();
        logic [31:0] v;
        v = $random(seed);
        if (v[7:0] >= `CMD_SET_R1 && v[7:0] <= `CMD_MUL) begin
            return v[7:0] ^ 8'h40;
        end
        return v[7:0];
    endfunction

    task automatic send_byte(input logic [7:0] data);
        logic [9:0] frame;
        frame = {1'b1, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            rxd <= frame[i];
            repeat (`CLKS_PER_BIT - 1) @(posedge clk);
        end
    endtask

    task automatic recv_byte(output logic [7:0] data);
        int waited;
        waited = 0;
        data = 8'h00;
        @(negedge clk);
        while (txd !== 1'b0 && waited < 12 * `CLKS_PER_BIT) begin
            @(negedge clk);
            waited++;
        end
        if (txd !== 1'b0) begin
            errors++;
            $display("No start bit on txd within 12 bit times at %0t", $time);
        end else begin
            repeat (`CLKS_PER_BIT / 2) @(negedge clk); // Middle of start bit
            if (txd !== 1'b0) begin
                errors++;
                $display("Start bit on txd too short at %0t", $time);
            end
            for (int i = 0; i < 8; i++) begin
                repeat (`CLKS_PER_BIT) @(negedge clk);
                data[i] = txd;
            end
            repeat (`CLKS_PER_BIT) @(negedge clk);
            if (txd !== 1'b1) begin
                errors++;
                $display("Missing stop bit on txd at %0t", $time);
            end
        end
    endtask

    task automatic check_quiet(input int cycles);
        bit seen_low;
        seen_low = 1'b0;
        repeat (cycles) begin
            @(negedge clk);
            if (txd !== 1'b1) begin
                seen_low = 1'b1;
            end
        end
        checks++;
        if (seen_low) begin
            errors++;
            $display("Unexpected activity on txd before %0t", $time);
        end
    endtask

    task automatic read_reply(input logic [7:0] cmd, input int nbytes,
                              input logic [23:0] expect_bytes);
        logic [7:0] got [3];
        fork
            send_byte(cmd);
            for (int i = 0; i < nbytes; i++) begin
                recv_byte(got[i]);
            end
        join
        for (int i = 0; i < nbytes; i++) begin
            checks++;
            if (got[i] !== expect_bytes[23 - 8 * i -: 8]) begin
                errors++;
                $display("Fail %0t: command %h byte %0d expected %h got %h", $time, cmd, i,
                         expect_bytes[23 - 8 * i -: 8], got[i]);
            end
        end
        check_quiet(2 * `CLKS_PER_BIT); // No extra reply bytes
    endtask

    task automatic set_reg(input bit to_r2, input logic [22:0] val);
        logic [31:0] v;
        v = $random(seed);
        send_byte(to_r2 ? `CMD_SET_R2 : `CMD_SET_R1);
        send_byte(val[22:15]);
        send_byte(val[14:7]);
        send_byte({val[6:0], v[0]}); // Spare bit, dropped by the DUT
        if (to_r2) begin
            m_r2 = val;
        end else begin
            m_r1 = val;
        end
    endtask

    task automatic model_op(input logic [7:0] cmd);
        int          ea;
        int          eb;
        int          e;
        int          ma;
        int          mb;
        int          mag;
        logic        sa;
        logic        sb;
        logic        s;
        logic        exact;
        logic [31:0] p;
        sa = m_r1[22];
        sb = m_r2[22] ^ (cmd == `CMD_SUB);
        ea = int'(m_r1[21:15]);
        eb = int'(m_r2[21:15]);
        ma = int'({1'b1, m_r1[14:0]});
        mb = int'({1'b1, m_r2[14:0]});
        exact = 1'b0;
        if (cmd == `CMD_MUL) begin
            s = sa ^ sb;
            if (ea == 0 || eb == 0) begin
                exact = 1'b1;
                e = 0;
                mag = 0;
            end else begin
                e = ea + eb - `EXP_BIAS;
                p = ma * mb;
                mag = p[31] ? int'(p[30:16]) : int'(p[29:15]);
                e = p[31] ? e + 1 : e;
            end
        end else if (ea == 0 || eb == 0) begin
            exact = 1'b1; // The nonzero side passes unchanged
            s = (ea == 0) ? sb : sa;
            e = (ea == 0) ? eb : ea;
            mag = ((ea == 0) ? mb : ma) % 32768;
        end else begin
            if (ea >= eb) begin
                mb = mb >> (ea - eb);
                e = ea;
            end else begin
                ma = ma >> (eb - ea);
                e = eb;
            end
            s = (ma > mb) ? sa : sb;
            mag = (sa == sb) ? ma + mb : ((ma > mb) ? ma - mb : mb - ma);
            s = (sa == sb) ? sa : s;
            if (mag == 0) begin
                exact = 1'b1; // Cancellation
                s = 1'b0;
                e = 0;
            end else if (mag >= 65536) begin
                mag = mag / 2;
                e = e + 1;
            end else begin
                while (mag < 32768) begin
                    mag = mag * 2;
                    e = e - 1;
                end
            end
        end
        if (!exact && e > `EXP_MAX) begin
            m_flags = 3'b010;
            m_res = {s, 7'(`EXP_MAX), 15'h7fff};
        end else if (!exact && e < 1) begin
            m_flags = 3'b101;
            m_res = '0;
        end else begin
            m_flags = {2'b00, e == 0};
            m_res = {s, 7'(e), 15'(mag)};
        end
    endtask

    task automatic run_op(input logic [7:0] cmd, input logic [22:0] op_a,
                          input logic [22:0] op_b);
        set_reg(1'b0, op_a);
        set_reg(1'b1, op_b);
        send_byte(cmd);
        model_op(cmd);
        read_reply(`CMD_READ_RES, 3, {m_res, 1'b0});
        read_reply(`CMD_READ_STAT, 1, {5'b0, m_flags, 16'h0});
    endtask

    initial begin
        reset <= 1'b1;
        rxd   <= 1'b1; // Line idles high
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        check_quiet(4 * `CLKS_PER_BIT);
        read_reply(`CMD_READ_R1, 3, 24'h0);
        read_reply(`CMD_READ_R2, 3, 24'h0);
        read_reply(`CMD_READ_RES, 3, 24'h0);
        read_reply(`CMD_READ_STAT, 1, 24'h0);

        for (int i = 0; i < 16; i++) begin
            set_reg(1'b0, rand_value());
            send_byte(junk_byte());
            set_reg(1'b1, rand_value());
            send_byte(junk_byte());
            read_reply(`CMD_READ_R1, 3, {m_r1, 1'b0});
            read_reply(`CMD_READ_R2, 3, {m_r2, 1'b0});
        end

        for (int i = 0; i < 32; i++) begin
            a = rand_value();
            b = rand_value();
            r = $random(seed);
            case (r[2:0])
                3'd0: a[21:15] = 7'd0;
                3'd1: b[21:15] = 7'd0;
                3'd2: b[21:15] = a[21:15];
                3'd3: b = {~a[22], a[21:0]}; // Same magnitude, other sign
                default: ;
            endcase
            run_op(r[3] ? `CMD_SUB : `CMD_ADD, a, b);
        end

        for (int i = 0; i < 24; i++) begin
            a = rand_value();
            b = rand_value();
            r = $random(seed);
            if (r[2:0] == 3'd0) begin
                a[21:15] = 7'd0;
            end
            if (r[2:0] == 3'd1) begin
                b[21:15] = 7'd0;
            end
            run_op(`CMD_MUL, a, b);
        end

        for (int i = 0; i < 4; i++) begin
            run_op(dir_op[i], dir_a[i], dir_b[i]);
            run_op(`CMD_ADD, rand_value(), rand_value()); // Flags clear again
        end

        finished = 1'b1;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: test/fpu_calc_checker.sv
/* Handshake assertions bound into the command controller
   FPU start and idle levels, and the UART transmit start */
`timescale 1ns/1ps
`default_nettype none

module fpu_calc_checker (
    input logic clk,
    input logic reset,
    input logic start,
    input logic idle,
    input logic tx_start,
    input logic tx_busy
);

    logic [4:0] busy_cycles; // Cycles with the FPU busy

    always_ff @(posedge clk) begin
        if (reset || idle) begin
            busy_cycles <= '0;
        end else if (busy_cycles != 5'd31) begin
            busy_cycles <= busy_cycles + 5'd1;
        end
    end

    start_when_idle: assert property (@(posedge clk) disable iff (reset) start |-> idle)
        else $error("FPU start pulse while the FPU is busy");

    idle_in_time: assert property (@(posedge clk) disable iff (reset) busy_cycles < 5'd20)
        else $error("FPU did not return to idle within 20 cycles");

    tx_start_when_free: assert property (@(posedge clk) disable iff (reset)
        tx_start |-> !tx_busy)
        else $error("Transmit start while the transmitter is busy");

endmodule

bind calc_ctrl fpu_calc_checker fpu_calc_checker_inst (
    .clk      (clk),
    .reset    (reset),
    .start    (start),
    .idle     (idle),
    .tx_start (tx_start),
    .tx_busy  (tx_busy)
);

`default_nettype wire

// File: rtl/fpu_calc_top.sv
/* Serial floating-point calculator
   UART receiver, command controller, FPU and UART transmitter */
`timescale 1ns/1ps
`default_nettype none

module fpu_calc_top (
    input  logic clk,
    input  logic reset,
    input  logic rxd,
    output logic txd
);

    fpu_calc_pkg::byte_t   rx_data;
    logic                  rx_valid;
    fpu_calc_pkg::byte_t   tx_data;
    logic                  tx_start;
    logic                  tx_busy;
    logic                  start;
    fpu_calc_pkg::fpu_op_t op;
    logic                  r1_s;
    fpu_calc_pkg::exp_t    r1_e;
    fpu_calc_pkg::man_t    r1_m;
    logic                  r2_s;
    fpu_calc_pkg::exp_t    r2_e;
    fpu_calc_pkg::man_t    r2_m;
    logic                  res_s;
    fpu_calc_pkg::exp_t    res_e;
    fpu_calc_pkg::man_t    res_m;
    logic                  zero_flag;
    logic                  overflow_flag;
    logic                  underflow_flag;
    logic                  idle;

    uart_rx uart_rx_inst (.*);

    calc_ctrl calc_ctrl_inst (.*);

    fpu_core fpu_core_inst (
        .a_s (r1_s),
        .a_e (r1_e),
        .a_m (r1_m),
        .b_s (r2_s),
        .b_e (r2_e),
        .b_m (r2_m),
        .*
    );

    uart_tx uart_tx_inst (.*);

endmodule

`default_nettype wire

// File: rtl/calc_ctrl.sv
/* Command decoder with the R1 and R2 operand registers
   Collects operand bytes, starts the FPU and sequences the serial replies */
`timescale 1ns/1ps
`default_nettype none
`include "fpu_calc_defs.svh"

module calc_ctrl (
    input  logic                  clk,
    input  logic                  reset,
    input  fpu_calc_pkg::byte_t   rx_data,
    input  logic                  rx_valid,
    input  logic                  tx_busy,
    output fpu_calc_pkg::byte_t   tx_data,
    output logic                  tx_start,
    output logic                  start,
    output fpu_calc_pkg::fpu_op_t op,
    output logic                  r1_s,
    output fpu_calc_pkg::exp_t    r1_e,
    output fpu_calc_pkg::man_t    r1_m,
    output logic                  r2_s,
    output fpu_calc_pkg::exp_t    r2_e,
    output fpu_calc_pkg::man_t    r2_m,
    input  logic                  res_s,
    input  fpu_calc_pkg::exp_t    res_e,
    input  fpu_calc_pkg::man_t    res_m,
    input  logic                  zero_flag,
    input  logic                  overflow_flag,
    input  logic                  underflow_flag,
    input  logic                  idle
);

    fpu_calc_pkg::ctrl_state_t state;
    logic [1:0]                byte_cnt;
    logic                      sel_r2;
    logic [23:0]               word; // Reply, sent high byte first

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= fpu_calc_pkg::C_IDLE;
            byte_cnt <= '0;
            sel_r2   <= 1'b0;
            word     <= '0;
            tx_data  <= '0;
            tx_start <= 1'b0;
            start    <= 1'b0;
            op       <= fpu_calc_pkg::OP_ADD;
            {r1_s, r1_e, r1_m} <= '0;
            {r2_s, r2_e, r2_m} <= '0;
        end else begin
            tx_start <= 1'b0;
            start    <= 1'b0;
            case (state)
                fpu_calc_pkg::C_IDLE: begin
                    byte_cnt <= 2'd3;
                    if (rx_valid) begin
                        case (rx_data)
                            `CMD_SET_R1, `CMD_SET_R2: begin
                                sel_r2   <= (rx_data == `CMD_SET_R2);
                                byte_cnt <= 2'd0;
                                state    <= fpu_calc_pkg::C_SET;
                            end
                            `CMD_READ_STAT: begin
                                word <= {5'b0, underflow_flag, overflow_flag, zero_flag, 16'h0};
                                byte_cnt <= 2'd1; // Status is a single byte
                                state    <= fpu_calc_pkg::C_REPLY;
                            end
                            `CMD_READ_R1: begin
                                word  <= {r1_s, r1_e, r1_m, 1'b0};
                                state <= fpu_calc_pkg::C_REPLY;
                            end
                            `CMD_READ_R2: begin
                                word  <= {r2_s, r2_e, r2_m, 1'b0};
                                state <= fpu_calc_pkg::C_REPLY;
                            end
                            `CMD_READ_RES: begin
                                word  <= {res_s, res_e, res_m, 1'b0};
                                state <= fpu_calc_pkg::C_REPLY;
                            end
                            `CMD_ADD, `CMD_SUB, `CMD_MUL: begin
                                if (rx_data == `CMD_ADD) begin
                                    op <= fpu_calc_pkg::OP_ADD;
                                end else if (rx_data == `CMD_SUB) begin
                                    op <= fpu_calc_pkg::OP_SUB;
                                end else begin
                                    op <= fpu_calc_pkg::OP_MUL;
                                end
                                start <= 1'b1;
                                state <= fpu_calc_pkg::C_START;
                            end
                            default: ; // Unknown bytes are dropped
                        endcase
                    end
                end
                fpu_calc_pkg::C_SET: begin
                    if (rx_valid) begin
                        byte_cnt <= byte_cnt + 2'd1;
                        case (byte_cnt)
                            2'd0: begin
                                if (sel_r2) {r2_s, r2_e} <= rx_data;
                                else        {r1_s, r1_e} <= rx_data;
                            end
                            2'd1: begin
                                if (sel_r2) r2_m[14:7] <= rx_data;
                                else        r1_m[14:7] <= rx_data;
                            end
                            default: begin
                                if (sel_r2) r2_m[6:0] <= rx_data[7:1];
                                else        r1_m[6:0] <= rx_data[7:1];
                                state <= fpu_calc_pkg::C_IDLE;
                            end
                        endcase
                    end
                end
                fpu_calc_pkg::C_REPLY: begin
                    // tx_busy rises only after the start pulse
                    if (!tx_busy && !tx_start) begin
                        if (byte_cnt == 2'd0) begin
                            state <= fpu_calc_pkg::C_IDLE;
                        end else begin
                            tx_data  <= word[23:16];
                            tx_start <= 1'b1;
                            word     <= {word[15:0], 8'h00};
                            byte_cnt <= byte_cnt - 2'd1;
                        end
                    end
                end
                fpu_calc_pkg::C_START: state <= fpu_calc_pkg::C_WAIT; // idle drops next
                fpu_calc_pkg::C_WAIT: begin
                    if (idle) begin
                        state <= fpu_calc_pkg::C_IDLE;
                    end
                end
                default: state <= fpu_calc_pkg::C_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/fpu_core.sv
/* Multicycle add, subtract and multiply on the 23-bit format
   Normalizes one left shift per cycle, truncates, and raises idle when done */
`timescale 1ns/1ps
`default_nettype none
`include "fpu_calc_defs.svh"

module fpu_core (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    input  fpu_calc_pkg::fpu_op_t op,
    input  logic                  a_s,
    input  fpu_calc_pkg::exp_t    a_e,
    input  fpu_calc_pkg::man_t    a_m,
    input  logic                  b_s,
    input  fpu_calc_pkg::exp_t    b_e,
    input  fpu_calc_pkg::man_t    b_m,
    output logic                  res_s,
    output fpu_calc_pkg::exp_t    res_e,
    output fpu_calc_pkg::man_t    res_m,
    output logic                  zero_flag,
    output logic                  overflow_flag,
    output logic                  underflow_flag,
    output logic                  idle
);

    fpu_calc_pkg::fpu_state_t state;
    fpu_calc_pkg::fpu_op_t    op_q;
    logic                     sa;
    logic                     sb;
    logic                     sign_r;
    logic                     bypass; // Exact result, no range check
    fpu_calc_pkg::exp_t       ea;
    fpu_calc_pkg::exp_t       eb;
    fpu_calc_pkg::sig_t       ma;
    fpu_calc_pkg::sig_t       mb;
    logic signed [9:0]        e_r;
    logic [16:0]              sum;    // Carry bit on top
    logic [31:0]              prod;

    assign prod = ma * mb;

    always_ff @(posedge clk) begin
        if (reset) begin
            state          <= fpu_calc_pkg::FPU_IDLE;
            op_q           <= fpu_calc_pkg::OP_ADD;
            {sa, sb}       <= 2'b00;
            sign_r         <= 1'b0;
            bypass         <= 1'b0;
            {ea, eb}       <= '0;
            {ma, mb}       <= '0;
            e_r            <= '0;
            sum            <= '0;
            res_s          <= 1'b0;
            res_e          <= '0;
            res_m          <= '0;
            zero_flag      <= 1'b0;
            overflow_flag  <= 1'b0;
            underflow_flag <= 1'b0;
            idle           <= 1'b1;
        end else begin
            case (state)
                fpu_calc_pkg::FPU_IDLE: begin
                    if (start) begin
                        op_q   <= op;
                        sa     <= a_s;
                        sb     <= (op == fpu_calc_pkg::OP_SUB) ? ~b_s : b_s;
                        ea     <= a_e;
                        eb     <= b_e;
                        ma     <= {1'b1, a_m};
                        mb     <= {1'b1, b_m};
                        bypass <= 1'b0;
                        idle   <= 1'b0;
                        state  <= fpu_calc_pkg::FPU_ALIGN;
                    end
                end
                fpu_calc_pkg::FPU_ALIGN: begin
                    if (op_q == fpu_calc_pkg::OP_MUL) begin
                        if (ea == '0 || eb == '0) begin
                            bypass <= 1'b1; // Signed zero
                            sign_r <= sa ^ sb;
                            e_r    <= '0;
                            sum    <= '0;
                            state  <= fpu_calc_pkg::FPU_PACK;
                        end else begin
                            e_r   <= 10'(ea) + 10'(eb) - 10'(`EXP_BIAS);
                            state <= fpu_calc_pkg::FPU_ADD;
                        end
                    end else if (ea == '0) begin
                        bypass <= 1'b1; // Other operand passes through
                        sign_r <= sb;
                        e_r    <= 10'(eb);
                        sum    <= {2'b00, mb[14:0]};
                        state  <= fpu_calc_pkg::FPU_PACK;
                    end else if (eb == '0) begin
                        bypass <= 1'b1;
                        sign_r <= sa;
                        e_r    <= 10'(ea);
                        sum    <= {2'b00, ma[14:0]};
                        state  <= fpu_calc_pkg::FPU_PACK;
                    end else if (ea >= eb) begin
                        mb    <= mb >> (ea - eb); // Tie shifts R2 by zero
                        e_r   <= 10'(ea);
                        state <= fpu_calc_pkg::FPU_ADD;
                    end else begin
                        ma    <= ma >> (eb - ea);
                        e_r   <= 10'(eb);
                        state <= fpu_calc_pkg::FPU_ADD;
                    end
                end
                fpu_calc_pkg::FPU_ADD: begin
                    if (op_q == fpu_calc_pkg::OP_MUL) begin
                        sign_r <= sa ^ sb;
                        if (prod[31]) begin
                            sum <= {2'b01, prod[30:16]};
                            e_r <= e_r + 10'sd1;
                        end else begin
                            sum <= {2'b01, prod[29:15]};
                        end
                        state <= fpu_calc_pkg::FPU_PACK;
                    end else if (sa == sb) begin
                        sign_r <= sa;
                        sum    <= {1'b0, ma} + {1'b0, mb};
                        state  <= fpu_calc_pkg::FPU_NORM;
                    end else if (ma == mb) begin
                        bypass <= 1'b1; // Full cancellation gives +0
                        sign_r <= 1'b0;
                        e_r    <= '0;
                        sum    <= '0;
                        state  <= fpu_calc_pkg::FPU_PACK;
                    end else if (ma > mb) begin
                        sign_r <= sa;
                        sum    <= {1'b0, ma - mb};
                        state  <= fpu_calc_pkg::FPU_NORM;
                    end else begin
                        sign_r <= sb;
                        sum    <= {1'b0, mb - ma};
                        state  <= fpu_calc_pkg::FPU_NORM;
                    end
                end
                fpu_calc_pkg::FPU_NORM: begin
                    if (sum[16]) begin
                        sum   <= sum >> 1; // Carry out
                        e_r   <= e_r + 10'sd1;
                        state <= fpu_calc_pkg::FPU_PACK;
                    end else if (sum[15]) begin
                        state <= fpu_calc_pkg::FPU_PACK;
                    end else begin
                        sum <= sum << 1;
                        e_r <= e_r - 10'sd1;
                    end
                end
                fpu_calc_pkg::FPU_PACK: begin
                    overflow_flag  <= 1'b0;
                    underflow_flag <= 1'b0;
                    if (!bypass && e_r > `EXP_MAX) begin
                        overflow_flag <= 1'b1; // Saturate
                        zero_flag     <= 1'b0;
                        res_s         <= sign_r;
                        res_e         <= 7'(`EXP_MAX);
                        res_m         <= '1;
                    end else if (!bypass && e_r < 10'sd1) begin
                        underflow_flag <= 1'b1;
                        zero_flag      <= 1'b1;
                        res_s          <= 1'b0;
                        res_e          <= '0;
                        res_m          <= '0;
                    end else begin
                        zero_flag <= (e_r == 10'sd0);
                        res_s     <= sign_r;
                        res_e     <= e_r[6:0];
                        res_m     <= sum[14:0];
                    end
                    idle  <= 1'b1;
                    state <= fpu_calc_pkg::FPU_IDLE;
                end
                default: state <= fpu_calc_pkg::FPU_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/uart_tx.sv
/* 8N1 serial transmitter, busy for the whole ten-bit frame */
`timescale 1ns/1ps
`default_nettype none
`include "fpu_calc_defs.svh"

module uart_tx (
    input  logic                clk,
    input  logic                reset,
    input  logic                tx_start,
    input  fpu_calc_pkg::byte_t tx_data,
    output logic                txd,
    output logic                tx_busy
);

    logic [15:0]             clk_cnt;
    logic [2:0]              bit_idx;
    fpu_calc_pkg::byte_t     shreg;
    fpu_calc_pkg::tx_state_t state;

    assign tx_busy = (state != fpu_calc_pkg::TX_IDLE);

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= fpu_calc_pkg::TX_IDLE;
            clk_cnt <= '0;
            bit_idx <= '0;
            shreg   <= '0;
            txd     <= 1'b1;
        end else begin
            case (state)
                fpu_calc_pkg::TX_IDLE: begin
                    clk_cnt <= '0;
                    if (tx_start) begin
                        shreg <= tx_data;
                        txd   <= 1'b0; // Start bit
                        state <= fpu_calc_pkg::TX_START;
                    end
                end
                fpu_calc_pkg::TX_START: begin
                    if (clk_cnt == 16'(`CLKS_PER_BIT - 1)) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        txd     <= shreg[0];
                        state   <= fpu_calc_pkg::TX_DATA;
                    end else begin
                        clk_cnt <= clk_cnt + 16'd1;
                    end
                end
                fpu_calc_pkg::TX_DATA: begin
                    if (clk_cnt == 16'(`CLKS_PER_BIT - 1)) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 3'd1;
                        shreg   <= shreg >> 1;
                        if (bit_idx == 3'd7) begin
                            txd   <= 1'b1; // Stop bit
                            state <= fpu_calc_pkg::TX_STOP;
                        end else begin
                            txd <= shreg[1];
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 16'd1;
                    end
                end
                fpu_calc_pkg::TX_STOP: begin
                    if (clk_cnt == 16'(`CLKS_PER_BIT - 1)) begin
                        state <= fpu_calc_pkg::TX_IDLE;
                    end else begin
                        clk_cnt <= clk_cnt + 16'd1;
                    end
                end
                default: state <= fpu_calc_pkg::TX_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/uart_rx.sv
/* 8N1 serial receiver
   Samples each bit at its centre and pulses rx_valid on a good stop bit */
`timescale 1ns/1ps
`default_nettype none
`include "fpu_calc_defs.svh"

module uart_rx (
    input  logic                clk,
    input  logic                reset,
    input  logic                rxd,
    output fpu_calc_pkg::byte_t rx_data,
    output logic                rx_valid
);

    logic                    rxd_meta;
    logic                    rxd_sync;
    logic [15:0]             clk_cnt;
    logic [2:0]              bit_idx;
    fpu_calc_pkg::rx_state_t state;

    always_ff @(posedge clk) begin
        if (reset) begin
            rxd_meta <= 1'b1; // Line idles high
            rxd_sync <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= fpu_calc_pkg::RX_IDLE;
            clk_cnt  <= '0;
            bit_idx  <= '0;
            rx_data  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                fpu_calc_pkg::RX_IDLE: begin
                    clk_cnt <= '0;
                    if (!rxd_sync) begin
                        state <= fpu_calc_pkg::RX_START;
                    end
                end
                fpu_calc_pkg::RX_START: begin
                    if (clk_cnt == 16'(`CLKS_PER_BIT / 2 - 1)) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        if (rxd_sync) begin
                            state <= fpu_calc_pkg::RX_IDLE; // Glitch, not a start bit
                        end else begin
                            state <= fpu_calc_pkg::RX_DATA;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 16'd1;
                    end
                end
                fpu_calc_pkg::RX_DATA: begin
                    if (clk_cnt == 16'(`CLKS_PER_BIT - 1)) begin
                        clk_cnt <= '0;
                        rx_data <= {rxd_sync, rx_data[7:1]}; // LSB first
                        bit_idx <= bit_idx + 3'd1;
                        if (bit_idx == 3'd7) begin
                            state <= fpu_calc_pkg::RX_STOP;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 16'd1;
                    end
                end
                fpu_calc_pkg::RX_STOP: begin
                    if (clk_cnt == 16'(`CLKS_PER_BIT - 1)) begin
                        rx_valid <= rxd_sync; // Framing error drops the byte
                        state    <= fpu_calc_pkg::RX_IDLE;
                    end else begin
                        clk_cnt <= clk_cnt + 16'd1;
                    end
                end
                default: state <= fpu_calc_pkg::RX_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/fpu_calc_pkg.sv
/* Field types and state encodings of the calculator */
`default_nettype none

package fpu_calc_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [6:0]  exp_t;  // Biased exponent, zero means zero
    typedef logic [14:0] man_t;
    typedef logic [15:0] sig_t;  // Fraction with hidden one

    typedef enum logic [1:0] {OP_ADD, OP_SUB, OP_MUL} fpu_op_t;

    typedef enum logic [2:0] {
        FPU_IDLE, FPU_ALIGN, FPU_ADD, FPU_NORM, FPU_PACK
    } fpu_state_t;

    typedef enum logic [2:0] {
        C_IDLE, C_SET, C_REPLY, C_START, C_WAIT
    } ctrl_state_t;

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;
    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

endpackage

`default_nettype wire

// File: fpu_calc_defs.svh
/* Shared constants for the serial floating-point calculator
   Bit timing, exponent limits and host command bytes */
`ifndef FPU_CALC_DEFS_SVH
`define FPU_CALC_DEFS_SVH

`define CLKS_PER_BIT 16 // Short bit time for simulation

`define EXP_BIAS 63
`define EXP_MAX  127

`define CMD_SET_R1    8'h82
`define CMD_SET_R2    8'h83
`define CMD_READ_STAT 8'h84
`define CMD_READ_R1   8'h85
`define CMD_READ_R2   8'h86
`define CMD_READ_RES  8'h87
`define CMD_ADD       8'h88
`define CMD_SUB       8'h89
`define CMD_MUL       8'h8A

`endif
